// ==== hw/dmr_settings.svh ====
// Global constants for the DMR lockstep subsystem
// Widths, register map, restore length and reset defaults
`ifndef DMR_SETTINGS_SVH
`define DMR_SETTINGS_SVH

// Bus widths
`define DMR_ADDR_W 32
`define DMR_DATA_W 32

// Register port address width
`define DMR_REG_AW 4

// Register offsets
`define DMR_REG_ENABLE   4'h0
`define DMR_REG_MISMATCH 4'h4
`define DMR_REG_STATUS   4'h8

// Restore length in cycles
`define DMR_RECOVERY_CYCLES 8

// Reset value of the enable bit
`define DMR_DEFAULT_ENABLE 1'b1

// Lockstep permanently on when set
`define DMR_FIXED 1'b0

`endif

// ==== hw/dmr_pkg.sv ====
// Request, register and mode types of the DMR lockstep subsystem
`include "dmr_settings.svh"

package dmr_pkg;

  // Instruction fetch request from one core
  // Valid stays the first field since the comparator reads the MSB
  typedef struct packed {
    logic                   valid;
    logic [`DMR_ADDR_W-1:0] addr;
  } fetch_req_t;

  // Data request from one core
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`DMR_ADDR_W-1:0] addr;
    logic [`DMR_DATA_W-1:0] wdata;
  } data_req_t;

  // Software register access
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`DMR_REG_AW-1:0] addr;
    logic [`DMR_DATA_W-1:0] wdata;
  } reg_req_t;

  // Register response given in the request cycle
  typedef struct packed {
    logic                   ready;
    logic                   error;
    logic [`DMR_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Redundancy mode
  // NON_DMR lets both cores run on their own
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Result of one lockstep compare
  typedef struct packed {
    logic mismatch;
    logic both_valid;
  } cmp_status_t;

endpackage

// ==== hw/dmr_compare.sv ====
// Registered lockstep comparator for one request stream
// Works on any packed payload whose first field is the valid bit
`timescale 1ns/100ps

module dmr_compare import dmr_pkg::*; #(
  parameter type payload_t = logic [1:0]
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  payload_t    a_i,
  input  payload_t    b_i,
  output payload_t    a_o,
  output payload_t    b_o,
  output cmp_status_t status_o
);

  localparam int PayloadW = $bits(payload_t);

  payload_t a_q, b_q;
  logic [PayloadW-1:0] a_bits, b_bits;
  logic a_valid, b_valid;

  // One register stage for both cores
  // New pair accepted every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  // Flat view of the payloads
  assign a_bits = a_q;
  assign b_bits = b_q;

  // Valid sits in the MSB of a packed struct
  assign a_valid = a_bits[PayloadW-1];
  assign b_valid = b_bits[PayloadW-1];

  // Whole-payload compare
  // One-sided valid also counts as a disagreement
  assign status_o.mismatch   = (a_valid | b_valid) && (a_bits != b_bits);
  assign status_o.both_valid = a_valid & b_valid;

  assign a_o = a_q;
  assign b_o = b_q;

endmodule

// ==== hw/dmr_regs.sv ====
// Software registers of the DMR subsystem
// Enable bit, saturating mismatch counter and mode status
`timescale 1ns/100ps
`include "dmr_settings.svh"

module dmr_regs import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  logic      dmr_enable_q_i,
  input  logic      dmr_enable_qe_i,
  input  logic      incr_mismatch_i,
  input  dmr_mode_e mode_i,
  output logic      dmr_enable_o
);

  localparam int CntW = 16;

  logic            enable_q;
  logic [CntW-1:0] mismatch_cnt_q;
  logic            hit_enable, hit_mismatch, hit_status;
  logic            wr_enable, wr_mismatch;

  // Address decode
  assign hit_enable   = reg_req_i.addr == `DMR_REG_ENABLE;
  assign hit_mismatch = reg_req_i.addr == `DMR_REG_MISMATCH;
  assign hit_status   = reg_req_i.addr == `DMR_REG_STATUS;

  // Software write strobes
  assign wr_enable   = reg_req_i.valid && reg_req_i.write && hit_enable;
  assign wr_mismatch = reg_req_i.valid && reg_req_i.write && hit_mismatch;

  // Enable bit
  // Hardware override beats a software write in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= `DMR_DEFAULT_ENABLE;
    end else if (dmr_enable_qe_i) begin
      enable_q <= dmr_enable_q_i;
    end else if (wr_enable) begin
      enable_q <= reg_req_i.wdata[0];
    end
  end

  // Mismatch counter
  // Any write clears it
  // Increments stop at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_cnt_q <= '0;
    end else if (wr_mismatch) begin
      mismatch_cnt_q <= '0;
    end else if (incr_mismatch_i && (mismatch_cnt_q != '1)) begin
      mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
    end
  end

  // Same-cycle response
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (hit_enable) begin
      reg_rsp_o.rdata = `DMR_DATA_W'(enable_q);
    end else if (hit_mismatch) begin
      reg_rsp_o.rdata = `DMR_DATA_W'(mismatch_cnt_q);
    end else if (hit_status) begin
      // Status word carries the current mode
      reg_rsp_o.rdata = `DMR_DATA_W'(mode_i);
    end else begin
      // Unknown offset leaves the data at zero
      reg_rsp_o.error = reg_req_i.valid;
    end
  end

  assign dmr_enable_o = enable_q;

endmodule

// ==== hw/hmr_dmr_ctrl.sv ====
// DMR mode FSM with independent, lockstep run and restore modes
// Raises setback, recovery request and mismatch increment pulses
`timescale 1ns/100ps
`include "dmr_settings.svh"

module hmr_dmr_ctrl import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      dmr_enable_i,
  input  logic      dmr_error_i,
  input  logic      recovery_finished_i,
  input  logic      fetch_en_i,
  input  logic      cores_synch_i,
  output dmr_mode_e mode_o,
  output logic      setback_o,
  output logic      grp_in_independent_o,
  output logic      incr_mismatch_o,
  output logic      recovery_request_o
);

  // Reset mode follows the enable default
  localparam dmr_mode_e DefaultMode =
      (`DMR_DEFAULT_ENABLE || `DMR_FIXED) ? DMR_RUN : NON_DMR;

  dmr_mode_e mode_d, mode_q;
  logic      recovery_req_d, recovery_req_q;
  logic      incr_d, incr_q;

  always_comb begin
    mode_d = mode_q;

    case (mode_q)
      DMR_RUN: begin
        // Rapid recovery is always on so every error restores
        if (dmr_error_i) begin
          mode_d = DMR_RESTORE;
        end
      end
      DMR_RESTORE: begin
        // Errors here are ignored until the restore ends
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    // Mode switching where later rules take priority
    if (!`DMR_FIXED) begin
      // Before fetch starts the mode tracks the enable bit
      if (!fetch_en_i) begin
        mode_d = dmr_enable_i ? DMR_RUN : NON_DMR;
      end
      // Leave lockstep any time software drops enable
      if ((mode_q == DMR_RUN) && !dmr_enable_i) begin
        mode_d = NON_DMR;
      end
      // Rejoin once the cores report they are in sync
      if ((mode_q == NON_DMR) && cores_synch_i && dmr_enable_i) begin
        mode_d = DMR_RUN;
      end
    end
  end

  // Request only on the entry into restore
  assign recovery_req_d = (mode_d == DMR_RESTORE) && (mode_q != DMR_RESTORE);

  // Count errors seen while in lockstep
  assign incr_d = (mode_q == DMR_RUN) && dmr_error_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q         <= DefaultMode;
      recovery_req_q <= 1'b0;
      incr_q         <= 1'b0;
    end else begin
      mode_q         <= mode_d;
      recovery_req_q <= recovery_req_d;
      incr_q         <= incr_d;
    end
  end

  assign mode_o               = mode_q;
  assign recovery_request_o   = recovery_req_q;
  // Setback coincides with the recovery request
  assign setback_o            = recovery_req_q;
  assign incr_mismatch_o      = incr_q;
  assign grp_in_independent_o = mode_q == NON_DMR;

endmodule

// ==== hw/dmr_recovery_seq.sv ====
// Recovery sequencer with fetch address checkpoint
// Times a fixed-length restore and presents the restore address
`timescale 1ns/100ps
`include "dmr_settings.svh"

module dmr_recovery_seq import dmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   recovery_request_i,
  input  fetch_req_t             fetch_i,
  input  cmp_status_t            fetch_status_i,
  output logic                   recovery_finished_o,
  output logic [`DMR_ADDR_W-1:0] restore_addr_o,
  output logic                   restore_valid_o
);

  localparam int CntW = $clog2(`DMR_RECOVERY_CYCLES + 1);

  logic                   busy_q;
  logic [CntW-1:0]        cnt_q;
  logic                   finished;
  logic [`DMR_ADDR_W-1:0] ckpt_q;

  // Finish lands exactly N cycles after the request
  assign finished = busy_q && (cnt_q == CntW'(`DMR_RECOVERY_CYCLES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (recovery_request_i) begin
      busy_q <= 1'b1;
      cnt_q  <= CntW'(1);
    end else if (finished) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  // Checkpoint the last agreed fetch address
  // Frozen from the request until the restore ends
  always_ff @(posedge clk_i) begin
    if (fetch_status_i.both_valid && !fetch_status_i.mismatch &&
        !busy_q && !recovery_request_i) begin
      ckpt_q <= fetch_i.addr;
    end
  end

  assign recovery_finished_o = finished;
  assign restore_valid_o     = finished;
  assign restore_addr_o      = ckpt_q;

endmodule

// ==== hw/dmr_lockstep_top.sv ====
// Top level of the DMR lockstep subsystem
// Compare stages, mode control, recovery, registers and forwarding gates
`timescale 1ns/100ps
`include "dmr_settings.svh"

module dmr_lockstep_top import dmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_req_t             core_a_fetch_i,
  input  fetch_req_t             core_b_fetch_i,
  input  data_req_t              core_a_data_i,
  input  data_req_t              core_b_data_i,
  input  reg_req_t               reg_req_i,
  input  logic                   dmr_enable_q_i,
  input  logic                   dmr_enable_qe_i,
  input  logic                   fetch_en_i,
  input  logic                   cores_synch_i,
  output fetch_req_t             fetch_a_o,
  output fetch_req_t             fetch_b_o,
  output data_req_t              data_a_o,
  output data_req_t              data_b_o,
  output reg_rsp_t               reg_rsp_o,
  output logic                   setback_o,
  output logic                   grp_in_independent_o,
  output logic                   recovery_request_o,
  output logic [`DMR_ADDR_W-1:0] restore_addr_o,
  output logic                   restore_valid_o
);

  fetch_req_t  fetch_a_q, fetch_b_q;
  data_req_t   data_a_q, data_b_q;
  cmp_status_t fetch_status, data_status;
  dmr_mode_e   dmr_mode;
  logic        dmr_error, dmr_enable, dmr_incr_mismatch;
  logic        recovery_finished;

  // Fetch stream compare
  dmr_compare #(.payload_t(fetch_req_t)) i_cmp_fetch (
    .clk_i, .rst_ni,
    .a_i(core_a_fetch_i), .b_i(core_b_fetch_i),
    .a_o(fetch_a_q), .b_o(fetch_b_q), .status_o(fetch_status)
  );

  // Data stream compare
  dmr_compare #(.payload_t(data_req_t)) i_cmp_data (
    .clk_i, .rst_ni,
    .a_i(core_a_data_i), .b_i(core_b_data_i),
    .a_o(data_a_q), .b_o(data_b_q), .status_o(data_status)
  );

  // Any disagreement on either stream
  assign dmr_error = fetch_status.mismatch | data_status.mismatch;

  hmr_dmr_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .dmr_enable_i(dmr_enable), .dmr_error_i(dmr_error),
    .recovery_finished_i(recovery_finished),
    .fetch_en_i, .cores_synch_i, .mode_o(dmr_mode), .setback_o,
    .grp_in_independent_o, .incr_mismatch_o(dmr_incr_mismatch), .recovery_request_o
  );

  dmr_recovery_seq i_recovery (
    .clk_i, .rst_ni,
    .recovery_request_i(recovery_request_o),
    .fetch_i(fetch_a_q), .fetch_status_i(fetch_status),
    .recovery_finished_o(recovery_finished), .restore_addr_o, .restore_valid_o
  );

  dmr_regs i_regs (
    .clk_i, .rst_ni, .reg_req_i, .reg_rsp_o,
    .dmr_enable_q_i, .dmr_enable_qe_i,
    .incr_mismatch_i(dmr_incr_mismatch), .mode_i(dmr_mode), .dmr_enable_o(dmr_enable)
  );

  // Forwarding gates
  // Lockstep keeps only core A
  // Restore blocks everything
  always_comb begin
    fetch_a_o = fetch_a_q;
    fetch_b_o = fetch_b_q;
    data_a_o  = data_a_q;
    data_b_o  = data_b_q;
    if (dmr_mode != NON_DMR) begin
      fetch_b_o.valid = 1'b0;
      data_b_o.valid  = 1'b0;
    end
    if (dmr_mode == DMR_RESTORE) begin
      fetch_a_o.valid = 1'b0;
      data_a_o.valid  = 1'b0;
    end
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
// Clock and reset generator for the DMR lockstep testbench
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PeriodNs   = 8.0,
  parameter int  ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== verification/dmr_assertions.sv ====
// Concurrent checks on the DMR mode FSM bound into hmr_dmr_ctrl
`timescale 1ns/100ps
`include "dmr_settings.svh"

module dmr_assertions import dmr_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      recovery_request_i,
  input logic      setback_i,
  input logic      recovery_finished_i,
  input dmr_mode_e mode_i
);

  // Request is a single-cycle pulse
  a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      recovery_request_i |=> !recovery_request_i)
    else $error("recovery request held for more than one cycle");

  // Setback and request both mark the first restore cycle
  a_setback_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (setback_i == recovery_request_i) &&
      (recovery_request_i == ((mode_i == DMR_RESTORE) && ($past(mode_i) != DMR_RESTORE))))
    else $error("setback or recovery request off the entry into restore");

  // Fixed restore length
  a_restore_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
      recovery_request_i |-> ##`DMR_RECOVERY_CYCLES recovery_finished_i)
    else $error("restore did not finish after the fixed length");

  // Finish only ever lands inside a restore
  a_finish_in_restore: assert property (@(posedge clk_i) disable iff (!rst_ni)
      recovery_finished_i |-> (mode_i == DMR_RESTORE))
    else $error("restore finish outside of restore mode");

endmodule

bind hmr_dmr_ctrl dmr_assertions i_dmr_assertions (
  .clk_i,
  .rst_ni,
  .recovery_request_i(recovery_request_o),
  .setback_i(setback_o),
  .recovery_finished_i(recovery_finished_i),
  .mode_i(mode_o)
);

// ==== verification/tb_dmr_lockstep.sv ====
// Testbench for the DMR lockstep top
// Stimulus, reference model, per-cycle checker and watchdog
`timescale 1ns/100ps
`include "dmr_settings.svh"

module tb_dmr_lockstep import dmr_pkg::*; ();

  // Reset plus worst-case cycles of each test in order
  localparam int TestCycles = 3 + 21 + 72 + 18 + 9 + 9;
  localparam int MarginCycles = 100;
  localparam int N = `DMR_RECOVERY_CYCLES;

  typedef struct packed {
    fetch_req_t fa;
    fetch_req_t fb;
    data_req_t  da;
    data_req_t  db;
  } fwd_t;

  logic clk_i, rst_ni;
  fetch_req_t core_a_fetch_i, core_b_fetch_i, fetch_a_o, fetch_b_o;
  data_req_t core_a_data_i, core_b_data_i, data_a_o, data_b_o;
  reg_req_t reg_req_i;
  reg_rsp_t reg_rsp_o;
  logic dmr_enable_q_i, dmr_enable_qe_i, fetch_en_i, cores_synch_i;
  logic setback_o, grp_in_independent_o, recovery_request_o, restore_valid_o;
  logic [`DMR_ADDR_W-1:0] restore_addr_o;

  logic [31:0] lfsr = 32'h76b4d719;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_errs_start;
  logic [31:0] last_agreed_addr;

  // Reference model state mirroring the registers after the last edge
  fetch_req_t m_fa, m_fb;
  data_req_t m_da, m_db;
  dmr_mode_e m_mode;
  logic m_req, m_incr, m_en, m_busy;
  int m_rcnt;
  logic [15:0] m_cnt;
  logic [31:0] m_ckpt;

  tb_clk_gen #(.PeriodNs(8.0), .ResetCycles(3)) i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  dmr_lockstep_top uut (.*);

  // Fibonacci LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic streams_differ(logic va, logic vb, logic [95:0] a, logic [95:0] b);
    return (va | vb) && (a != b);
  endfunction

  // Expected forwarded requests for a mode and registered payloads
  function automatic fwd_t predict_fwd(dmr_mode_e m, fetch_req_t fa, fetch_req_t fb,
                                       data_req_t da, data_req_t db);
    fwd_t e;
    e.fa = fa;
    e.fb = fb;
    e.da = da;
    e.db = db;
    if (m != NON_DMR) begin
      e.fb.valid = 1'b0;
      e.db.valid = 1'b0;
    end
    if (m == DMR_RESTORE) begin
      e.fa.valid = 1'b0;
      e.da.valid = 1'b0;
    end
    return e;
  endfunction

  // Next mode from the switching rules where later rules win
  function automatic dmr_mode_e predict_mode(dmr_mode_e m, logic en, logic err, logic fin,
                                             logic fen, logic synch);
    dmr_mode_e nm;
    nm = m;
    if (m == DMR_RUN && err) nm = DMR_RESTORE;
    if (m == DMR_RESTORE && fin) nm = DMR_RUN;
    if (!fen) nm = en ? DMR_RUN : NON_DMR;
    if (m == DMR_RUN && !en) nm = NON_DMR;
    if (m == NON_DMR && synch && en) nm = DMR_RUN;
    return nm;
  endfunction

  function automatic reg_req_t mk_req(logic wr, logic [3:0] a, logic [31:0] d);
    reg_req_t r;
    r.valid = 1'b1;
    r.write = wr;
    r.addr = a;
    r.wdata = d;
    return r;
  endfunction

  task automatic report(string name, logic [95:0] got, logic [95:0] exp);
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic fail_plain(string what);
    $display("%0t %s", $time, what);
    err_cnt++;
  endtask

  // Kind 0 matching, 1 data mismatch, 2 idle, 3 independent random
  task automatic tick(int kind, reg_req_t rq = '0, logic synch = 1'b0,
                      logic qe = 1'b0, logic qval = 1'b0);
    fetch_req_t f;
    data_req_t d;
    @(posedge clk_i);
    #1;
    f.valid = 1'b1;
    f.addr = rand_bits(32);
    d.valid = 1'b1;
    d.we = rand_bits(1);
    d.addr = rand_bits(32);
    d.wdata = rand_bits(32);
    if (kind == 2) begin
      f = '0;
      d = '0;
    end
    core_a_fetch_i = f;
    core_b_fetch_i = f;
    core_a_data_i = d;
    core_b_data_i = d;
    if (kind == 1) core_b_data_i.wdata = ~d.wdata;
    if (kind == 3) begin
      core_b_fetch_i.valid = rand_bits(1);
      core_b_fetch_i.addr = rand_bits(32);
      core_b_data_i.valid = rand_bits(1);
      core_b_data_i.wdata = rand_bits(32);
    end
    if (kind <= 1) last_agreed_addr = f.addr;
    reg_req_i = rq;
    cores_synch_i = synch;
    dmr_enable_qe_i = qe;
    dmr_enable_q_i = qval;
  endtask

  task automatic read_reg(logic [3:0] a, logic [31:0] exp, string name);
    tick(0, mk_req(1'b0, a, '0));
    @(negedge clk_i);
    if (reg_rsp_o.rdata !== exp) report(name, reg_rsp_o.rdata, exp);
  endtask

  task automatic start_test();
    test_errs_start = err_cnt;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (err_cnt != test_errs_start) tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_errs_start);
  endtask

  // Reference model and per-cycle checks at the falling edge
  always @(negedge clk_i) begin
    fwd_t e;
    logic err, fin, fmis;
    logic [31:0] exp_rd;
    logic exp_err;
    dmr_mode_e nm;
    if (!rst_ni) begin
      m_fa = '0;
      m_fb = '0;
      m_da = '0;
      m_db = '0;
      m_mode = (`DMR_DEFAULT_ENABLE) ? DMR_RUN : NON_DMR;
      m_req = 1'b0;
      m_incr = 1'b0;
      m_en = `DMR_DEFAULT_ENABLE;
      m_busy = 1'b0;
      m_rcnt = 0;
      m_cnt = '0;
    end else begin
      e = predict_fwd(m_mode, m_fa, m_fb, m_da, m_db);
      fin = m_busy && (m_rcnt == N);
      if (fetch_a_o !== e.fa) report("fetch_a_o", fetch_a_o, e.fa);
      if (fetch_b_o !== e.fb) report("fetch_b_o", fetch_b_o, e.fb);
      if (data_a_o !== e.da) report("data_a_o", data_a_o, e.da);
      if (data_b_o !== e.db) report("data_b_o", data_b_o, e.db);
      if (recovery_request_o !== m_req) report("recovery_request_o", recovery_request_o, m_req);
      if (setback_o !== m_req) report("setback_o", setback_o, m_req);
      if (grp_in_independent_o !== (m_mode == NON_DMR))
        report("grp_in_independent_o", grp_in_independent_o, m_mode == NON_DMR);
      if (restore_valid_o !== fin) report("restore_valid_o", restore_valid_o, fin);
      if (fin && restore_addr_o !== m_ckpt) report("restore_addr_o", restore_addr_o, m_ckpt);
      // Same-cycle register response
      exp_err = 1'b0;
      case (reg_req_i.addr)
        `DMR_REG_ENABLE:   exp_rd = {31'b0, m_en};
        `DMR_REG_MISMATCH: exp_rd = {16'b0, m_cnt};
        `DMR_REG_STATUS:   exp_rd = {30'b0, m_mode};
        default: begin
          exp_rd = '0;
          exp_err = 1'b1;
        end
      endcase
      if (reg_req_i.valid) begin
        if (reg_rsp_o.ready !== 1'b1) report("reg_rsp_o.ready", reg_rsp_o.ready, 1'b1);
        if (reg_rsp_o.error !== exp_err) report("reg_rsp_o.error", reg_rsp_o.error, exp_err);
        if (reg_rsp_o.rdata !== exp_rd) report("reg_rsp_o.rdata", reg_rsp_o.rdata, exp_rd);
      end
      // Advance the model with the inputs captured at the next edge
      fmis = streams_differ(m_fa.valid, m_fb.valid, m_fa, m_fb);
      err = fmis || streams_differ(m_da.valid, m_db.valid, m_da, m_db);
      nm = predict_mode(m_mode, m_en, err, fin, fetch_en_i, cores_synch_i);
      if (m_fa.valid && m_fb.valid && !fmis && !m_busy && !m_req) m_ckpt = m_fa.addr;
      if (m_req) begin
        m_busy = 1'b1;
        m_rcnt = 1;
      end else if (fin) begin
        m_busy = 1'b0;
        m_rcnt = 0;
      end else if (m_busy) begin
        m_rcnt++;
      end
      if (reg_req_i.valid && reg_req_i.write && reg_req_i.addr == `DMR_REG_MISMATCH)
        m_cnt = '0;
      else if (m_incr && m_cnt != 16'hffff)
        m_cnt = m_cnt + 1'b1;
      m_incr = (m_mode == DMR_RUN) && err;
      m_req = (nm == DMR_RESTORE) && (m_mode != DMR_RESTORE);
      if (dmr_enable_qe_i)
        m_en = dmr_enable_q_i;
      else if (reg_req_i.valid && reg_req_i.write && reg_req_i.addr == `DMR_REG_ENABLE)
        m_en = reg_req_i.wdata[0];
      m_mode = nm;
      m_fa = core_a_fetch_i;
      m_fb = core_b_fetch_i;
      m_da = core_a_data_i;
      m_db = core_b_data_i;
    end
  end

  // Watchdog sized from the summed test lengths
  initial begin
    #((TestCycles + MarginCycles) * 8);
    $display("Watchdog expired before the tests completed");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int cycles;
    logic [31:0] exp_ckpt;
    logic seen;
    core_a_fetch_i = '0;
    core_b_fetch_i = '0;
    core_a_data_i = '0;
    core_b_data_i = '0;
    reg_req_i = '0;
    dmr_enable_q_i = 1'b0;
    dmr_enable_qe_i = 1'b0;
    fetch_en_i = 1'b1;
    cores_synch_i = 1'b0;
    @(posedge rst_ni);

    start_test();
    read_reg(`DMR_REG_STATUS, 32'd1, "status after reset");
    repeat (20) tick(0);
    end_test("reset mode and lockstep forwarding");

    // Detected data mismatch enters restore
    start_test();
    repeat (5) tick(0);
    tick(1);
    exp_ckpt = last_agreed_addr;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < 20) begin
      tick(2);
      cycles++;
      @(negedge clk_i);
      seen = recovery_request_o;
    end
    if (!seen) fail_plain("recovery request never raised after the data mismatch");
    else if (cycles != 2) report("recovery_request_o delay", cycles, 2);
    // Valid requests keep arriving so the restore gating is exercised
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < 40) begin
      tick(0);
      cycles++;
      @(negedge clk_i);
      seen = restore_valid_o;
    end
    if (!seen) fail_plain("restore never finished");
    else begin
      if (cycles != N) report("restore length", cycles, N);
      if (restore_addr_o !== exp_ckpt) report("restore_addr_o", restore_addr_o, exp_ckpt);
    end
    repeat (4) tick(0);
    read_reg(`DMR_REG_MISMATCH, 32'd1, "mismatch count");
    read_reg(`DMR_REG_STATUS, 32'd1, "status after restore");
    end_test("mismatch recovery");

    // Independent mode
    start_test();
    tick(0, mk_req(1'b1, `DMR_REG_ENABLE, 32'd0));
    repeat (2) tick(0);
    @(negedge clk_i);
    if (grp_in_independent_o !== 1'b1) report("grp_in_independent_o", grp_in_independent_o, 1);
    seen = 1'b0;
    repeat (12) begin
      tick(3);
      @(negedge clk_i);
      if (recovery_request_o) seen = 1'b1;
    end
    if (seen) fail_plain("recovery requested while in independent mode");
    tick(0);
    read_reg(`DMR_REG_MISMATCH, 32'd1, "mismatch count in independent mode");
    read_reg(`DMR_REG_STATUS, 32'd0, "status independent");
    end_test("independent mode");

    // Rejoin lockstep only on cores_synch_i
    start_test();
    tick(0, mk_req(1'b1, `DMR_REG_ENABLE, 32'd1));
    repeat (4) tick(0);
    read_reg(`DMR_REG_STATUS, 32'd0, "status without synch");
    tick(0, '0, 1'b1);
    tick(0);
    read_reg(`DMR_REG_STATUS, 32'd1, "status after synch");
    end_test("rejoin lockstep");

    // Register port details
    start_test();
    tick(0, mk_req(1'b1, `DMR_REG_ENABLE, 32'd0), 1'b0, 1'b1, 1'b1);
    read_reg(`DMR_REG_ENABLE, 32'd1, "enable after override");
    read_reg(`DMR_REG_STATUS, 32'd1, "status after override");
    tick(0, mk_req(1'b1, `DMR_REG_MISMATCH, 32'd5));
    read_reg(`DMR_REG_MISMATCH, 32'd0, "mismatch after clear");
    tick(0, mk_req(1'b0, 4'hc, '0));
    @(negedge clk_i);
    if (reg_rsp_o.error !== 1'b1) report("reg_rsp_o.error", reg_rsp_o.error, 1);
    if (reg_rsp_o.rdata !== '0) report("reg_rsp_o.rdata", reg_rsp_o.rdata, 0);
    repeat (3) tick(2);
    end_test("register port");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hw
hw/dmr_pkg.sv
hw/dmr_compare.sv
hw/dmr_regs.sv
hw/hmr_dmr_ctrl.sv
hw/dmr_recovery_seq.sv
hw/dmr_lockstep_top.sv
verification/tb_clk_gen.sv
verification/dmr_assertions.sv
verification/tb_dmr_lockstep.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the DMR lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_dmr_lockstep -o sim_dmr

./obj_dir/sim_dmr > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
